/* all.f */
+incdir+include
src/ifu_dec_pkg.sv
src/ifu_op_classify.sv
src/ifu_imm_gen.sv
src/ifu_issue_stage.sv
src/ifu_dec_top.sv
sim/ifu_dec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=ifu_dec_sim

verilator --binary --timing --assert -f all.f --top-module ifu_dec_tb -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "compile failed with status $status"
   exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
   echo "simulation failed"
   exit 1
fi

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

echo "simulation passed"
exit 0

/* sim/ifu_dec_tb.sv */
`timescale 1ns/100ps

`include "ifu_dec_defines.svh"

module ifu_dec_tb import ifu_dec_pkg::*; ();

   // instruction kinds, grouped alu / lsu / bru / trap
   localparam int K_ADD = 0, K_SUB = 1, K_SLT = 2, K_AND = 3, K_OR = 4, K_XOR = 5;
   localparam int K_ADDI = 6, K_SLTI = 7, K_ANDI = 8, K_ORI = 9, K_XORI = 10;
   localparam int K_LU12I = 11, K_PCADDU12I = 12;
   localparam int K_LDB = 13, K_LDW = 14, K_STB = 15, K_STW = 16;
   localparam int K_BEQ = 17, K_BNE = 18, K_BLT = 19, K_B = 20, K_BL = 21, K_JIRL = 22;
   localparam int K_SYSCALL = 23, K_BREAK = 24, K_INE = 25;
   localparam int N_KINDS = 26;

   localparam int N_RANDOM = 400;
   localparam int TOTAL_CYCLES = 10 + 3 + 2 * N_KINDS + N_KINDS + N_RANDOM + 2;
   localparam int MARGIN_CYCLES = 50;

   logic       clk;
   logic       reset;
   inst_t      inst;
   gr_t        pc;
   logic       inst_vld;
   gr_t        rs1_data;
   gr_t        rs2_data;
   reg_idx_t   rs1;
   reg_idx_t   rs2;
   alu_issue_t alu_issue;
   lsu_issue_t lsu_issue;
   bru_issue_t bru_issue;
   exc_issue_t exc;

   integer seed;
   int     cur_kind;
   int     prev_kind;
   inst_t  prev_inst;
   gr_t    prev_pc;
   logic   prev_vld;
   logic   seen_vld;
   logic   x_alu;
   logic   x_lsu;
   logic   x_load;
   logic   x_bru;
   logic   x_exc;

   ifu_dec_top uut (
      .clk       (clk),
      .reset     (reset),
      .inst      (inst),
      .pc        (pc),
      .inst_vld  (inst_vld),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data),
      .rs1       (rs1),
      .rs2       (rs2),
      .alu_issue (alu_issue),
      .lsu_issue (lsu_issue),
      .bru_issue (bru_issue),
      .exc       (exc)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   // register file contents, a fixed pattern of the index
   function automatic gr_t rf_value(input reg_idx_t idx);
      return {3'b101, idx, 3'b011, ~idx, 3'b110, idx, 3'b001, ~idx};
   endfunction

   function automatic inst_t build_inst(input int kind, input logic [31:0] r);
      case (kind)
         K_ADD:       return {`OPC_ADD_W, r[14:0]};
         K_SUB:       return {`OPC_SUB_W, r[14:0]};
         K_SLT:       return {`OPC_SLT, r[14:0]};
         K_AND:       return {`OPC_AND, r[14:0]};
         K_OR:        return {`OPC_OR, r[14:0]};
         K_XOR:       return {`OPC_XOR, r[14:0]};
         K_ADDI:      return {`OPC_ADDI_W, r[21:0]};
         K_SLTI:      return {`OPC_SLTI, r[21:0]};
         K_ANDI:      return {`OPC_ANDI, r[21:0]};
         K_ORI:       return {`OPC_ORI, r[21:0]};
         K_XORI:      return {`OPC_XORI, r[21:0]};
         K_LU12I:     return {`OPC_LU12I_W, r[24:0]};
         K_PCADDU12I: return {`OPC_PCADDU12I, r[24:0]};
         K_LDB:       return {`OPC_LD_B, r[21:0]};
         K_LDW:       return {`OPC_LD_W, r[21:0]};
         K_STB:       return {`OPC_ST_B, r[21:0]};
         K_STW:       return {`OPC_ST_W, r[21:0]};
         K_BEQ:       return {`OPC_BEQ, r[25:0]};
         K_BNE:       return {`OPC_BNE, r[25:0]};
         K_BLT:       return {`OPC_BLT, r[25:0]};
         K_B:         return {`OPC_B, r[25:0]};
         K_BL:        return {`OPC_BL, r[25:0]};
         K_JIRL:      return {`OPC_JIRL, r[25:0]};
         K_SYSCALL:   return {`OPC_SYSCALL, r[14:0]};
         K_BREAK:     return {`OPC_BREAK, r[14:0]};
         // top six bits all ones match no opcode
         default:     return {6'h3f, r[25:0]};
      endcase
   endfunction

   function automatic alu_op_t alu_op_for(input int kind);
      case (kind)
         K_SUB:                  return `ALU_OP_SUB;
         K_SLT, K_SLTI:          return `ALU_OP_SLT;
         K_AND, K_ANDI:          return `ALU_OP_AND;
         K_OR, K_ORI:            return `ALU_OP_OR;
         K_XOR, K_XORI:          return `ALU_OP_XOR;
         K_LU12I:                return `ALU_OP_LUI;
         default:                return `ALU_OP_ADD;
      endcase
   endfunction

   function automatic bru_op_t bru_op_for(input int kind);
      case (kind)
         K_BEQ:   return `BRU_OP_BEQ;
         K_BNE:   return `BRU_OP_BNE;
         K_BLT:   return `BRU_OP_BLT;
         K_B:     return `BRU_OP_B;
         K_BL:    return `BRU_OP_BL;
         default: return `BRU_OP_JIRL;
      endcase
   endfunction

   function automatic gr_t sext_si12(input inst_t i);
      return {{20{i[21]}}, i[21:10]};
   endfunction

   // expected operand a and b of an alu instruction
   function automatic gr_t alu_a_for(input int kind, input inst_t i, input gr_t p);
      if (kind == K_LU12I)
         return '0;
      if (kind == K_PCADDU12I)
         return p;
      return rf_value(i[9:5]);
   endfunction

   function automatic gr_t alu_b_for(input int kind, input inst_t i);
      if (kind <= K_XOR)
         return rf_value(i[14:10]);
      if (kind == K_ADDI || kind == K_SLTI)
         return sext_si12(i);
      if (kind == K_LU12I || kind == K_PCADDU12I)
         return {i[24:5], 12'h000};
      return {20'h00000, i[21:10]};
   endfunction

   function automatic gr_t branch_offset(input int kind, input inst_t i);
      if (kind == K_B || kind == K_BL)
         return {{4{i[9]}}, i[9:0], i[25:10], 2'b00};
      return {{14{i[25]}}, i[25:10], 2'b00};
   endfunction

   function automatic exccode_t exc_code_for(input int kind);
      case (kind)
         K_SYSCALL: return `EXC_SYS;
         K_BREAK:   return `EXC_BRK;
         default:   return `EXC_INE;
      endcase
   endfunction

   // stores and compare branches read rd as the second source
   function automatic logic reads_rd(input int kind);
      return kind == K_STB || kind == K_STW || kind == K_BEQ || kind == K_BNE || kind == K_BLT;
   endfunction

   task automatic report_failure(input string msg);
      $display("FAILED at time %0t: %s", $time, msg);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   // drive one instruction slot on the next rising edge
   task automatic present(input int kind, input logic vld);
      logic [31:0] r;
      logic [31:0] p;
      r = $random(seed);
      p = $random(seed);
      @(posedge clk);
      inst <= build_inst(kind, r);
      pc <= {p[31:2], 2'b00};
      inst_vld <= vld;
      cur_kind <= kind;
   endtask

   ////////////////////////////////////////////////////////////
   // register file and reference model
   ////////////////////////////////////////////////////////////

   assign rs1_data = rf_value(rs1);
   assign rs2_data = rf_value(rs2);

   always_ff @(posedge clk) begin
      prev_inst <= inst;
      prev_pc <= pc;
      prev_kind <= cur_kind;
      if (reset) begin
         prev_vld <= 1'b0;
         seen_vld <= 1'b0;
      end else begin
         prev_vld <= inst_vld;
         seen_vld <= seen_vld | inst_vld;
      end
   end

   assign x_alu = prev_vld && prev_kind <= K_PCADDU12I;
   assign x_lsu = prev_vld && prev_kind >= K_LDB && prev_kind <= K_STW;
   assign x_load = prev_vld && (prev_kind == K_LDB || prev_kind == K_LDW);
   assign x_bru = prev_vld && prev_kind >= K_BEQ && prev_kind <= K_JIRL;
   assign x_exc = prev_vld && prev_kind >= K_SYSCALL;

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   a_idle: assert property (@(posedge clk) disable iff (reset)
      !seen_vld |-> !(alu_issue.wen || lsu_issue.valid || lsu_issue.wen
                      || bru_issue.valid || exc.flag))
      else report_failure("control output high before the first valid instruction");

   a_ctrl: assert property (@(posedge clk) disable iff (reset)
      alu_issue.wen == x_alu && lsu_issue.valid == x_lsu && lsu_issue.wen == x_load
      && bru_issue.valid == x_bru && exc.flag == x_exc)
      else report_failure("issue control bits differ from the reference model");

   a_alu: assert property (@(posedge clk) disable iff (reset)
      x_alu |-> alu_issue.op == alu_op_for(prev_kind)
                && alu_issue.a == alu_a_for(prev_kind, prev_inst, prev_pc)
                && alu_issue.b == alu_b_for(prev_kind, prev_inst)
                && alu_issue.b_is_imm == (prev_kind > K_XOR)
                && alu_issue.target == prev_inst[4:0])
      else report_failure("wrong alu bundle");

   a_lsu: assert property (@(posedge clk) disable iff (reset)
      x_lsu |-> lsu_issue.op == lsu_op_t'(prev_kind - K_LDB)
                && lsu_issue.rd == prev_inst[4:0]
                && lsu_issue.imm == sext_si12(prev_inst))
      else report_failure("wrong lsu bundle");

   a_bru: assert property (@(posedge clk) disable iff (reset)
      x_bru |-> bru_issue.op == bru_op_for(prev_kind)
                && bru_issue.offset == branch_offset(prev_kind, prev_inst))
      else report_failure("wrong bru bundle");

   a_link: assert property (@(posedge clk) disable iff (reset)
      (x_bru && prev_kind == K_BL) |-> alu_issue.target == 5'd1)
      else report_failure("bl does not target r1");

   a_exc: assert property (@(posedge clk) disable iff (reset)
      x_exc |-> exc.exccode == exc_code_for(prev_kind))
      else report_failure("wrong exception code");

   // read ports follow the instruction in the same cycle
   a_src: assert property (@(posedge clk) disable iff (reset)
      rs1 == inst[9:5] && rs2 == (reads_rd(cur_kind) ? inst[4:0] : inst[14:10]))
      else report_failure("wrong source register index");

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   initial begin
      #((TOTAL_CYCLES + MARGIN_CYCLES) * 100);
      $display("run timed out after %0d cycles", TOTAL_CYCLES + MARGIN_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
   end

   initial begin
      int          kind;
      logic [31:0] r;
      seed = 97376;
      reset = 1'b1;
      inst = '0;
      pc = '0;
      inst_vld = 1'b0;
      cur_kind = K_INE;
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      // idle slots after reset
      repeat (3) present(K_INE, 1'b0);

      // every kind twice, back to back
      for (int rep = 0; rep < 2; rep++) begin
         for (int k = 0; k < N_KINDS; k++) begin
            present(k, 1'b1);
         end
      end

      // empty slots carrying real encodings
      for (int k = 0; k < N_KINDS; k++) begin
         present(k, 1'b0);
      end

      // seeded mix, mostly valid
      for (int n = 0; n < N_RANDOM; n++) begin
         r = $random(seed);
         kind = int'(r % 32'd26);
         present(kind, r[31:30] != 2'b00);
      end

      repeat (2) present(K_INE, 1'b0);
      @(posedge clk);
      $display("NO ERRORS");
      $finish;
   end

endmodule

/* src/ifu_dec_top.sv */
`timescale 1ns/100ps

module ifu_dec_top import ifu_dec_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  inst_t      inst,
   input  gr_t        pc,
   input  logic       inst_vld,
   input  gr_t        rs1_data,
   input  gr_t        rs2_data,
   output reg_idx_t   rs1,
   output reg_idx_t   rs2,
   output alu_issue_t alu_issue,
   output lsu_issue_t lsu_issue,
   output bru_issue_t bru_issue,
   output exc_issue_t exc
);

   dec_op_t  op;
   imm_set_t imm;

   // classifier and immediate forms work side by side on the raw word
   ifu_op_classify u_classify (
      .inst (inst),
      .op   (op)
   );

   ifu_imm_gen u_imm_gen (
      .inst (inst),
      .imm  (imm)
   );

   ifu_issue_stage u_issue (
      .clk       (clk),
      .reset     (reset),
      .inst      (inst),
      .pc        (pc),
      .inst_vld  (inst_vld),
      .op        (op),
      .imm       (imm),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data),
      .rs1       (rs1),
      .rs2       (rs2),
      .alu_issue (alu_issue),
      .lsu_issue (lsu_issue),
      .bru_issue (bru_issue),
      .exc       (exc)
   );

endmodule

/* src/ifu_issue_stage.sv */
`timescale 1ns/100ps

`include "ifu_dec_defines.svh"

module ifu_issue_stage import ifu_dec_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  inst_t      inst,
   input  gr_t        pc,
   input  logic       inst_vld,
   input  dec_op_t    op,
   input  imm_set_t   imm,
   input  gr_t        rs1_data,
   input  gr_t        rs2_data,
   output reg_idx_t   rs1,
   output reg_idx_t   rs2,
   output alu_issue_t alu_issue,
   output lsu_issue_t lsu_issue,
   output bru_issue_t bru_issue,
   output exc_issue_t exc
);

   logic       exc_d;
   logic       alu_disp;
   logic       lsu_disp;
   logic       bru_disp;
   logic       b_is_imm_d;
   exccode_t   exccode_d;
   reg_idx_t   target_d;
   gr_t        imm_sel;
   alu_issue_t alu_d;
   lsu_issue_t lsu_d;
   bru_issue_t bru_d;
   exc_issue_t exc_d_bundle;

   ////////////////////////////////////////////////////////////
   // dispatch
   ////////////////////////////////////////////////////////////

   assign exc_d = op.is_syscall | op.is_break | op.is_ine;

   // no dispatch for an empty slot or a trapping instruction
   assign alu_disp = (op.unit == `UNIT_ALU) & inst_vld & ~exc_d;
   assign lsu_disp = (op.unit == `UNIT_LSU) & inst_vld & ~exc_d;
   assign bru_disp = (op.unit == `UNIT_BRU) & inst_vld & ~exc_d;

   // register file read ports
   assign rs1 = inst[9:5];
   assign rs2 = op.rd_as_rs2 ? inst[4:0] : inst[14:10];

   // bl links through r1
   assign target_d = op.link_r1 ? reg_idx_t'(1) : inst[4:0];

   always_comb begin
      case (op.imm_kind)
         `IMM_UI12: imm_sel = imm.ui12;
         `IMM_SI20: imm_sel = imm.si20;
         default:   imm_sel = imm.si12;
      endcase
   end

   assign b_is_imm_d = (op.imm_kind != `IMM_NONE) & alu_disp;

   assign exccode_d = op.is_syscall ? `EXC_SYS :
                      op.is_break   ? `EXC_BRK :
                      op.is_ine     ? `EXC_INE :
                                      '0;

   ////////////////////////////////////////////////////////////
   // next bundles
   ////////////////////////////////////////////////////////////

   always_comb begin
      alu_d.wen = alu_disp & op.reg_write;
      alu_d.op = op.alu_op;
      alu_d.a = op.a_is_zero ? '0 : (op.a_is_pc ? pc : rs1_data);
      alu_d.b = b_is_imm_d ? imm_sel : rs2_data;
      alu_d.b_is_imm = b_is_imm_d;
      alu_d.target = target_d;

      lsu_d.valid = lsu_disp;
      lsu_d.op = op.lsu_op;
      lsu_d.wen = lsu_disp & op.reg_write;
      lsu_d.rd = inst[4:0];
      lsu_d.imm = imm.si12;

      // b and bl take the 26-bit offset
      bru_d.valid = bru_disp;
      bru_d.op = op.bru_op;
      bru_d.offset = (op.bru_op == `BRU_OP_B || op.bru_op == `BRU_OP_BL) ?
                     imm.offs26 : imm.offs16;

      exc_d_bundle.flag = exc_d & inst_vld;
      exc_d_bundle.exccode = exccode_d;
   end

   // d to e registers, only the control bits are cleared
   always_ff @(posedge clk) begin
      alu_issue <= alu_d;
      lsu_issue <= lsu_d;
      bru_issue <= bru_d;
      exc <= exc_d_bundle;
      if (reset) begin
         alu_issue.wen <= 1'b0;
         lsu_issue.valid <= 1'b0;
         lsu_issue.wen <= 1'b0;
         bru_issue.valid <= 1'b0;
         exc.flag <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   a_one_issue: assert property (@(posedge clk) disable iff (reset)
      $onehot0({alu_issue.wen, lsu_issue.valid, bru_issue.valid}))
      else $error("more than one issue path active");

   // a trap at e never travels with an issue valid
   a_exc_alone: assert property (@(posedge clk) disable iff (reset)
      exc.flag |-> !(alu_issue.wen || lsu_issue.valid || bru_issue.valid))
      else $error("exception issued together with a valid");

endmodule

/* src/ifu_imm_gen.sv */
`timescale 1ns/100ps

`include "ifu_dec_defines.svh"

module ifu_imm_gen import ifu_dec_pkg::*; (
   input  inst_t    inst,
   output imm_set_t imm
);

   ////////////////////////////////////////////////////////////
   // raw instruction fields
   ////////////////////////////////////////////////////////////

   logic [11:0] i12;
   logic [19:0] i20;
   logic [15:0] offs16_raw;
   logic [25:0] offs26_raw;

   // 2RI12 immediate
   assign i12 = inst[21:10];

   // 1RI20 immediate
   assign i20 = inst[24:5];

   // branch offsets, 26-bit form keeps its high part in inst[9:0]
   assign offs16_raw = inst[25:10];
   assign offs26_raw = {inst[9:0], inst[25:10]};

   ////////////////////////////////////////////////////////////
   // extended forms
   ////////////////////////////////////////////////////////////

   // arithmetic, compare and memory offset
   assign imm.si12 = {{(`GRLEN-12){i12[11]}}, i12};

   // andi / ori / xori
   assign imm.ui12 = {{(`GRLEN-12){1'b0}}, i12};

   // lu12i.w / pcaddu12i, low 12 bits cleared
   assign imm.si20 = {i20, {(`GRLEN-20){1'b0}}};

   // word aligned branch offsets
   assign imm.offs16 = {{(`GRLEN-18){offs16_raw[15]}}, offs16_raw, 2'b00};
   assign imm.offs26 = {{(`GRLEN-28){offs26_raw[25]}}, offs26_raw, 2'b00};

endmodule

/* src/ifu_op_classify.sv */
`timescale 1ns/100ps

`include "ifu_dec_defines.svh"

module ifu_op_classify import ifu_dec_pkg::*; (
   input  inst_t   inst,
   output dec_op_t op
);

   logic alu_rr;
   logic alu_ri;
   logic lsu_hit;
   logic bru_hit;

   always_comb begin
      op = '0;
      op.unit = `UNIT_NONE;
      op.imm_kind = `IMM_NONE;
      alu_rr = 1'b0;
      alu_ri = 1'b0;
      lsu_hit = 1'b0;
      bru_hit = 1'b0;

      ////////////////////////////////////////////////////////////
      // 3R forms and system calls, inst[31:15]
      ////////////////////////////////////////////////////////////
      case (inst[31:15])
         `OPC_ADD_W:   begin alu_rr = 1'b1; op.alu_op = `ALU_OP_ADD; end
         `OPC_SUB_W:   begin alu_rr = 1'b1; op.alu_op = `ALU_OP_SUB; end
         `OPC_SLT:     begin alu_rr = 1'b1; op.alu_op = `ALU_OP_SLT; end
         `OPC_AND:     begin alu_rr = 1'b1; op.alu_op = `ALU_OP_AND; end
         `OPC_OR:      begin alu_rr = 1'b1; op.alu_op = `ALU_OP_OR;  end
         `OPC_XOR:     begin alu_rr = 1'b1; op.alu_op = `ALU_OP_XOR; end
         `OPC_SYSCALL: op.is_syscall = 1'b1;
         `OPC_BREAK:   op.is_break = 1'b1;
         default: ;
      endcase

      // 2RI12 forms, inst[31:22]
      case (inst[31:22])
         `OPC_ADDI_W: begin
            alu_ri = 1'b1;
            op.alu_op = `ALU_OP_ADD;
            op.imm_kind = `IMM_SI12;
         end
         `OPC_SLTI: begin
            alu_ri = 1'b1;
            op.alu_op = `ALU_OP_SLT;
            op.imm_kind = `IMM_SI12;
         end
         // logical immediates are zero extended
         `OPC_ANDI: begin
            alu_ri = 1'b1;
            op.alu_op = `ALU_OP_AND;
            op.imm_kind = `IMM_UI12;
         end
         `OPC_ORI: begin
            alu_ri = 1'b1;
            op.alu_op = `ALU_OP_OR;
            op.imm_kind = `IMM_UI12;
         end
         `OPC_XORI: begin
            alu_ri = 1'b1;
            op.alu_op = `ALU_OP_XOR;
            op.imm_kind = `IMM_UI12;
         end
         `OPC_LD_B: begin lsu_hit = 1'b1; op.lsu_op = `LSU_OP_LDB; op.reg_write = 1'b1; end
         `OPC_LD_W: begin lsu_hit = 1'b1; op.lsu_op = `LSU_OP_LDW; op.reg_write = 1'b1; end
         // store data comes from the rd field
         `OPC_ST_B: begin lsu_hit = 1'b1; op.lsu_op = `LSU_OP_STB; op.rd_as_rs2 = 1'b1; end
         `OPC_ST_W: begin lsu_hit = 1'b1; op.lsu_op = `LSU_OP_STW; op.rd_as_rs2 = 1'b1; end
         default: ;
      endcase

      // 1RI20 forms, inst[31:25]
      case (inst[31:25])
         `OPC_LU12I_W: begin
            alu_ri = 1'b1;
            op.alu_op = `ALU_OP_LUI;
            op.imm_kind = `IMM_SI20;
            op.a_is_zero = 1'b1;
         end
         `OPC_PCADDU12I: begin
            alu_ri = 1'b1;
            op.alu_op = `ALU_OP_ADD;
            op.imm_kind = `IMM_SI20;
            op.a_is_pc = 1'b1;
         end
         default: ;
      endcase

      // branches, inst[31:26]
      case (inst[31:26])
         `OPC_BEQ:  begin bru_hit = 1'b1; op.bru_op = `BRU_OP_BEQ; op.rd_as_rs2 = 1'b1; end
         `OPC_BNE:  begin bru_hit = 1'b1; op.bru_op = `BRU_OP_BNE; op.rd_as_rs2 = 1'b1; end
         `OPC_BLT:  begin bru_hit = 1'b1; op.bru_op = `BRU_OP_BLT; op.rd_as_rs2 = 1'b1; end
         `OPC_B:    begin bru_hit = 1'b1; op.bru_op = `BRU_OP_B; end
         `OPC_BL: begin
            bru_hit = 1'b1;
            op.bru_op = `BRU_OP_BL;
            op.reg_write = 1'b1;
            op.link_r1 = 1'b1;
         end
         `OPC_JIRL: begin bru_hit = 1'b1; op.bru_op = `BRU_OP_JIRL; op.reg_write = 1'b1; end
         default: ;
      endcase

      if (alu_rr || alu_ri) begin
         op.unit = `UNIT_ALU;
         op.reg_write = 1'b1;
      end
      if (lsu_hit) begin
         op.unit = `UNIT_LSU;
         op.imm_kind = `IMM_SI12;
      end
      if (bru_hit) begin
         op.unit = `UNIT_BRU;
      end

      // nothing matched
      op.is_ine = !(alu_rr || alu_ri || lsu_hit || bru_hit || op.is_syscall || op.is_break);
   end

   // a trapping instruction must never name an issue unit
   always_comb begin
      a_exc_no_unit: assert final (!(op.is_syscall || op.is_break || op.is_ine)
                                   || op.unit == `UNIT_NONE)
         else $error("exception decoded with unit class %0d", op.unit);
   end

endmodule

/* src/ifu_dec_pkg.sv */
package ifu_dec_pkg;

`include "ifu_dec_defines.svh"

   ////////////////////////////////////////////////////////////
   // plain vector types
   ////////////////////////////////////////////////////////////

   typedef logic [`GRLEN-1:0]     gr_t;
   typedef logic [`REG_IDX_W-1:0] reg_idx_t;
   typedef logic [31:0]           inst_t;
   typedef logic [`EXCCODE_W-1:0] exccode_t;

   typedef logic [`ALU_OP_W-1:0]  alu_op_t;
   typedef logic [`LSU_OP_W-1:0]  lsu_op_t;
   typedef logic [`BRU_OP_W-1:0]  bru_op_t;

   // UNIT_* and IMM_* values
   typedef logic [1:0]            unit_t;
   typedef logic [1:0]            imm_kind_t;

   ////////////////////////////////////////////////////////////
   // bundles
   ////////////////////////////////////////////////////////////

   // classifier result
   typedef struct packed {
      unit_t     unit;
      alu_op_t   alu_op;
      lsu_op_t   lsu_op;
      bru_op_t   bru_op;
      imm_kind_t imm_kind;
      logic      rd_as_rs2;
      logic      reg_write;
      logic      a_is_pc;
      logic      a_is_zero;
      logic      link_r1;
      logic      is_syscall;
      logic      is_break;
      logic      is_ine;
   } dec_op_t;

   // every immediate form, formed in parallel
   typedef struct packed {
      gr_t si12;
      gr_t ui12;
      gr_t si20;
      gr_t offs16;
      gr_t offs26;
   } imm_set_t;

   typedef struct packed {
      logic     wen;
      alu_op_t  op;
      gr_t      a;
      gr_t      b;
      logic     b_is_imm;
      reg_idx_t target;
   } alu_issue_t;

   typedef struct packed {
      logic     valid;
      lsu_op_t  op;
      logic     wen;
      reg_idx_t rd;
      gr_t      imm;
   } lsu_issue_t;

   typedef struct packed {
      logic    valid;
      bru_op_t op;
      gr_t     offset;
   } bru_issue_t;

   typedef struct packed {
      logic     flag;
      exccode_t exccode;
   } exc_issue_t;

endpackage

/* include/ifu_dec_defines.svh */
`ifndef IFU_DEC_DEFINES_SVH
`define IFU_DEC_DEFINES_SVH

// widths
`define GRLEN      32
`define REG_IDX_W  5
`define EXCCODE_W  6
`define ALU_OP_W   4
`define LSU_OP_W   2
`define BRU_OP_W   3

////////////////////////////////////////////////////////////
// opcode match values, bits above the register fields
////////////////////////////////////////////////////////////

// inst[31:15]
`define OPC_ADD_W      17'h00020
`define OPC_SUB_W      17'h00022
`define OPC_SLT        17'h00024
`define OPC_AND        17'h00029
`define OPC_OR         17'h0002a
`define OPC_XOR        17'h0002b
`define OPC_BREAK      17'h00054
`define OPC_SYSCALL    17'h00056

// inst[31:22]
`define OPC_SLTI       10'h008
`define OPC_ADDI_W     10'h00a
`define OPC_ANDI       10'h00d
`define OPC_ORI        10'h00e
`define OPC_XORI       10'h00f
`define OPC_LD_B       10'h0a0
`define OPC_LD_W       10'h0a2
`define OPC_ST_B       10'h0a4
`define OPC_ST_W       10'h0a6

// inst[31:25]
`define OPC_LU12I_W    7'h0a
`define OPC_PCADDU12I  7'h0e

// inst[31:26]
`define OPC_JIRL       6'h13
`define OPC_B          6'h14
`define OPC_BL         6'h15
`define OPC_BEQ        6'h16
`define OPC_BNE        6'h17
`define OPC_BLT        6'h18

////////////////////////////////////////////////////////////
// operation codes
////////////////////////////////////////////////////////////

`define ALU_OP_ADD   4'd0
`define ALU_OP_SUB   4'd1
`define ALU_OP_SLT   4'd2
`define ALU_OP_AND   4'd3
`define ALU_OP_OR    4'd4
`define ALU_OP_XOR   4'd5
`define ALU_OP_LUI   4'd6

`define LSU_OP_LDB   2'd0
`define LSU_OP_LDW   2'd1
`define LSU_OP_STB   2'd2
`define LSU_OP_STW   2'd3

`define BRU_OP_BEQ   3'd0
`define BRU_OP_BNE   3'd1
`define BRU_OP_BLT   3'd2
`define BRU_OP_B     3'd3
`define BRU_OP_BL    3'd4
`define BRU_OP_JIRL  3'd5

// unit class
`define UNIT_NONE    2'd0
`define UNIT_ALU     2'd1
`define UNIT_LSU     2'd2
`define UNIT_BRU     2'd3

// immediate form for the alu b operand
`define IMM_SI12     2'd0
`define IMM_UI12     2'd1
`define IMM_SI20     2'd2
`define IMM_NONE     2'd3

// exception codes
`define EXC_SYS      6'h0b
`define EXC_BRK      6'h0c
`define EXC_INE      6'h0d

`endif
